/* design/csr_file.sv */
module csr_file (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         wb_valid,
  input  rf_pkg::csr_op_e              op,
  input  logic [rf_pkg::csr_addr_w-1:0] waddr,
  input  logic [rf_pkg::csr_addr_w-1:0] raddr,
  input  logic [rf_pkg::xlen-1:0]       wdata,
  input  logic [rf_pkg::xlen-1:0]       pc,
  input  rf_pkg::csr_rsel_e            rsel,
  output logic [rf_pkg::xlen-1:0]       rdata
);

  import rf_pkg::*;

  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mstatus_mret;

  // ##########################################################################
  // mret status update
  // ##########################################################################

  // MIE takes MPIE, MPIE is set and MPP drops back to user encoding
  always_comb begin
    mstatus_mret                          = mstatus;
    mstatus_mret[mstatus_mie_bit]         = mstatus[mstatus_mpie_bit];
    mstatus_mret[mstatus_mpie_bit]        = 1'b1;
    mstatus_mret[mstatus_mpp_lo +: 2]     = 2'b00;
  end

  // ##########################################################################
  // CSR state
  // ##########################################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec   <= '0;
      mepc    <= '0;
      mstatus <= mstatus_reset;
      mcause  <= '0;
    end else if (wb_valid) begin
      case (op)
        csr_op_write: begin
          // mvendorid, marchid and unknown addresses drop the write
          case (waddr)
            csr_mtvec:   mtvec   <= wdata;
            csr_mepc:    mepc    <= wdata;
            csr_mstatus: mstatus <= wdata;
            csr_mcause:  mcause  <= wdata;
            default: ;
          endcase
        end
        csr_op_ecall: begin
          mepc    <= pc;
          mcause  <= mcause_ecall_m;
          mstatus <= mstatus_reset;
        end
        csr_op_mret: begin
          mstatus <= mstatus_mret;
        end
        default: ;
      endcase
    end
  end

  // ##########################################################################
  // read mux
  // ##########################################################################

  // trap and return selects feed the jump target of ecall and mret
  always_comb begin
    case (rsel)
      csr_rsel_trap: rdata = mtvec;
      csr_rsel_ret:  rdata = mepc;
      csr_rsel_addr: begin
        case (raddr)
          csr_mtvec:     rdata = mtvec;
          csr_mepc:      rdata = mepc;
          csr_mstatus:   rdata = mstatus;
          csr_mcause:    rdata = mcause;
          csr_mvendorid: rdata = mvendorid_value;
          csr_marchid:   rdata = marchid_value;
          default:       rdata = '0;
        endcase
      end
      default: rdata = '0;
    endcase
  end

  // ##########################################################################
  // checks
  // ##########################################################################

  a_mret_status: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wb_valid && (op == csr_op_mret)) |=>
      ((mstatus[mstatus_mpp_lo +: 2] == 2'b00) && mstatus[mstatus_mpie_bit])
  ) else $error("mstatus after mret is %h", mstatus);

  a_ecall_cause: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wb_valid && (op == csr_op_ecall)) |=> (mcause == mcause_ecall_m)
  ) else $error("mcause after ecall is %h", mcause);

  // state only moves on a write-back cycle
  a_csr_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    !wb_valid |=>
      ($stable(mtvec) && $stable(mepc) && $stable(mstatus) && $stable(mcause))
  ) else $error("CSR changed without wb_valid");

endmodule

/* design/gpr_bank.sv */
module gpr_bank (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         we,
  input  logic [rf_pkg::reg_addr_w-1:0] waddr,
  input  logic [rf_pkg::reg_addr_w-1:0] raddr1,
  input  logic [rf_pkg::reg_addr_w-1:0] raddr2,
  input  logic [rf_pkg::xlen-1:0]       wdata,
  output logic [rf_pkg::xlen-1:0]       rdata1,
  output logic [rf_pkg::xlen-1:0]       rdata2
);

  import rf_pkg::*;

  logic [xlen-1:0] regs [0:2**reg_addr_w-1];

  // ##########################################################################
  // write port
  // ##########################################################################

  // x0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // ##########################################################################
  // read ports
  // ##########################################################################

  // no bypass from the write port, a write shows up after the edge
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  a_x0_read1: assert property (
    @(posedge clk) disable iff (!arst_n)
    (raddr1 == '0) |-> (rdata1 == '0)
  ) else $error("x0 read on port 1 returned %h", rdata1);

  a_x0_read2: assert property (
    @(posedge clk) disable iff (!arst_n)
    (raddr2 == '0) |-> (rdata2 == '0)
  ) else $error("x0 read on port 2 returned %h", rdata2);

endmodule

/* design/reg_unit.sv */
module reg_unit (
  input  logic                         clk,
  input  logic                         arst_n,

  // decode read requests
  input  logic [rf_pkg::reg_addr_w-1:0] rs1,
  input  logic [rf_pkg::reg_addr_w-1:0] rs2,
  input  logic [rf_pkg::csr_addr_w-1:0] csr_addr,
  input  rf_pkg::csr_rsel_e            csr_rsel,
  output logic [rf_pkg::xlen-1:0]       src1,
  output logic [rf_pkg::xlen-1:0]       src2,
  output logic [rf_pkg::xlen-1:0]       csr_data,

  // write-back
  input  logic                         wb_valid,
  input  logic [rf_pkg::xlen-1:0]       wb_pc,
  input  logic                         wb_gpr_wen,
  input  logic [rf_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rf_pkg::xlen-1:0]       wb_gpr_wdata,
  input  rf_pkg::csr_op_e              wb_csr_op,
  input  logic [rf_pkg::csr_addr_w-1:0] wb_csr_addr,
  input  logic [rf_pkg::xlen-1:0]       wb_csr_wdata
);

  logic gpr_we;

  // the bank handles the x0 rule, only the strobe is qualified here
  assign gpr_we = wb_valid & wb_gpr_wen;

  // ##########################################################################
  // general registers
  // ##########################################################################

  gpr_bank u_gpr (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (gpr_we),
    .waddr  (wb_rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (wb_gpr_wdata),
    .rdata1 (src1),
    .rdata2 (src2)
  );

  // ##########################################################################
  // machine CSRs
  // ##########################################################################

  // a csrrw commits to both blocks in the same cycle
  csr_file u_csr (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_valid (wb_valid),
    .op       (wb_csr_op),
    .waddr    (wb_csr_addr),
    .raddr    (csr_addr),
    .wdata    (wb_csr_wdata),
    .pc       (wb_pc),
    .rsel     (csr_rsel),
    .rdata    (csr_data)
  );

endmodule

/* design/rf_pkg.sv */
package rf_pkg;

  // ##########################################################################
  // widths
  // ##########################################################################

  localparam int unsigned xlen       = 32;
  // RV32E has sixteen general registers
  localparam int unsigned reg_addr_w = 4;
  localparam int unsigned csr_addr_w = 12;

  // ##########################################################################
  // machine CSR addresses
  // ##########################################################################

  localparam logic [csr_addr_w-1:0] csr_mstatus   = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec     = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc      = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause    = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hF11;
  localparam logic [csr_addr_w-1:0] csr_marchid   = 12'hF12;

  // MPP set to machine mode, also the value written on ecall
  localparam logic [xlen-1:0] mstatus_reset   = 32'h0000_1800;
  localparam logic [xlen-1:0] mcause_ecall_m  = 32'd11;
  localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_value   = 32'h017D_C685;

  // mstatus fields touched by mret, MPP is two bits wide
  localparam int unsigned mstatus_mie_bit  = 3;
  localparam int unsigned mstatus_mpie_bit = 7;
  localparam int unsigned mstatus_mpp_lo   = 11;

  // ##########################################################################
  // opcodes
  // ##########################################################################

  typedef enum logic [1:0] {
    csr_op_none  = 2'd0,
    csr_op_write = 2'd1,
    csr_op_ecall = 2'd2,
    csr_op_mret  = 2'd3
  } csr_op_e;

  typedef enum logic [1:0] {
    csr_rsel_addr = 2'd0,
    csr_rsel_trap = 2'd1,
    csr_rsel_ret  = 2'd2
  } csr_rsel_e;

endpackage

/* files.f */
design/rf_pkg.sv
design/gpr_bank.sv
design/csr_file.sv
design/reg_unit.sv
tb/tb_reg_unit.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench and the RTL with Verilator, then run it from the project root
# the simulator exits non-zero on $fatal, which makes this script fail
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_reg_unit -f files.f &&
  ./obj_dir/Vtb_reg_unit ||
  exit 1

/* tb/reg_unit_golden.txt */
# name wb_valid wb_gpr_wen wb_rd wb_gpr_wdata wb_csr_op wb_csr_addr wb_csr_wdata wb_pc
#   rs1 rs2 csr_addr csr_rsel exp_src1 exp_src2 exp_csr, all hex
# csr_op 0 none 1 write 2 ecall 3 mret, csr_rsel 0 addr 1 trap 2 ret
rst_x0 0 0 0 00000000 0 000 00000000 00000000 0 1 300 0 00000000 00000000 00001800
rst_x15 0 0 0 00000000 0 000 00000000 00000000 f e 305 0 00000000 00000000 00000000
rst_mepc 0 0 0 00000000 0 000 00000000 00000000 2 3 341 0 00000000 00000000 00000000
rst_mcause 0 0 0 00000000 0 000 00000000 00000000 4 5 342 0 00000000 00000000 00000000
rst_vendor 0 0 0 00000000 0 000 00000000 00000000 6 7 f11 0 00000000 00000000 79737978
rst_arch 0 0 0 00000000 0 000 00000000 00000000 8 9 f12 0 00000000 00000000 017dc685
gpr_w1 1 1 1 11111111 0 000 00000000 00000000 1 1 300 0 00000000 00000000 00001800
gpr_r1 1 1 2 22222222 0 000 00000000 00000000 1 2 300 0 11111111 00000000 00001800
gpr_r2 1 1 f ffffffff 0 000 00000000 00000000 2 f 300 0 22222222 00000000 00001800
gpr_x0w 1 1 0 deadbeef 0 000 00000000 00000000 f 1 300 0 ffffffff 11111111 00001800
gpr_x0r 0 1 3 33333333 0 000 00000000 00000000 0 2 300 0 00000000 22222222 00001800
gpr_nov 0 0 0 00000000 0 000 00000000 00000000 3 0 300 0 00000000 00000000 00001800
gpr_wen0 1 0 3 44444444 0 000 00000000 00000000 3 f 300 0 00000000 ffffffff 00001800
gpr_wen0r 0 0 0 00000000 0 000 00000000 00000000 3 1 300 0 00000000 11111111 00001800
csr_mtvec_w 1 0 0 00000000 1 305 00000100 00000000 0 0 305 0 00000000 00000000 00000000
csr_mepc_w 1 0 0 00000000 1 341 00000200 00000000 0 0 305 0 00000000 00000000 00000100
csr_mcause_w 1 0 0 00000000 1 342 00000007 00000000 0 0 341 0 00000000 00000000 00000200
csr_mstatus_w 1 0 0 00000000 1 300 00000088 00000000 0 0 342 0 00000000 00000000 00000007
csr_ro_w1 1 0 0 00000000 1 f11 12345678 00000000 0 0 300 0 00000000 00000000 00000088
csr_ro_w2 1 0 0 00000000 1 f12 12345678 00000000 0 0 f11 0 00000000 00000000 79737978
csr_unk_w 1 0 0 00000000 1 7c0 aaaaaaaa 00000000 0 0 f12 0 00000000 00000000 017dc685
csr_unk_r 0 0 0 00000000 0 000 00000000 00000000 0 0 7c0 0 00000000 00000000 00000000
csr_nov 0 0 0 00000000 1 305 bbbbbbbb 00000000 0 0 305 0 00000000 00000000 00000100
csr_nov_r 0 0 0 00000000 0 000 00000000 00000000 0 0 305 0 00000000 00000000 00000100
csrrw 1 1 4 00000100 1 305 00000400 00000000 4 0 305 0 00000000 00000000 00000100
csrrw_r 0 0 0 00000000 0 000 00000000 00000000 4 0 305 0 00000100 00000000 00000400
ecall 1 0 0 00000000 2 000 00000000 00001234 0 0 000 1 00000000 00000000 00000400
ecall_mepc 0 0 0 00000000 0 000 00000000 00000000 0 0 341 0 00000000 00000000 00001234
ecall_cause 0 0 0 00000000 0 000 00000000 00000000 0 0 342 0 00000000 00000000 0000000b
ecall_status 0 0 0 00000000 0 000 00000000 00000000 0 0 300 0 00000000 00000000 00001800
ecall_trap 0 0 0 00000000 0 000 00000000 00000000 0 0 000 1 00000000 00000000 00000400
mret_set_a 1 0 0 00000000 1 300 00001880 00000000 0 0 300 0 00000000 00000000 00001800
mret_a 1 0 0 00000000 3 000 00000000 00000000 0 0 300 0 00000000 00000000 00001880
mret_a_r 0 0 0 00000000 0 000 00000000 00000000 0 0 300 0 00000000 00000000 00000088
mret_set_b 1 0 0 00000000 1 300 00001808 00000000 0 0 300 0 00000000 00000000 00000088
mret_b 1 0 0 00000000 3 000 00000000 00000000 0 0 300 0 00000000 00000000 00001808
mret_b_r 0 0 0 00000000 0 000 00000000 00000000 0 0 300 0 00000000 00000000 00000080
mret_ret 0 0 0 00000000 0 000 00000000 00000000 0 0 000 2 00000000 00000000 00001234
mret_nov 0 0 0 00000000 3 000 00000000 00000000 0 0 300 0 00000000 00000000 00000080
mret_nov_r 0 0 0 00000000 0 000 00000000 00000000 0 0 300 0 00000000 00000000 00000080
gpr_final 0 0 0 00000000 0 000 00000000 00000000 1 f f11 0 11111111 ffffffff 79737978

/* tb/tb_reg_unit.sv */
module tb_reg_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import rf_pkg::*;

  localparam int clk_period    = 20;
  localparam int reset_cycles  = 8;
  localparam int margin_cycles = 100;
  localparam string golden_path = "tb/reg_unit_golden.txt";

  // one golden line, fields in file order
  typedef struct packed {
    logic                  wb_valid;
    logic                  wb_gpr_wen;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_gpr_wdata;
    logic [1:0]            wb_csr_op;
    logic [csr_addr_w-1:0] wb_csr_addr;
    logic [xlen-1:0]       wb_csr_wdata;
    logic [xlen-1:0]       wb_pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [csr_addr_w-1:0] csr_addr;
    logic [1:0]            csr_rsel;
    logic [xlen-1:0]       exp_src1;
    logic [xlen-1:0]       exp_src2;
    logic [xlen-1:0]       exp_csr;
  } vec_t;

  logic                  clk;
  logic                  arst_n;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [csr_addr_w-1:0] csr_addr;
  csr_rsel_e             csr_rsel;
  logic [xlen-1:0]       src1;
  logic [xlen-1:0]       src2;
  logic [xlen-1:0]       csr_data;
  logic                  wb_valid;
  logic [xlen-1:0]       wb_pc;
  logic                  wb_gpr_wen;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_gpr_wdata;
  csr_op_e               wb_csr_op;
  logic [csr_addr_w-1:0] wb_csr_addr;
  logic [xlen-1:0]       wb_csr_wdata;

  vec_t  vecs[$];
  string names[$];
  int    n_vec  = 0;
  bit    loaded = 1'b0;

  reg_unit i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .rs1          (rs1),
    .rs2          (rs2),
    .csr_addr     (csr_addr),
    .csr_rsel     (csr_rsel),
    .src1         (src1),
    .src2         (src2),
    .csr_data     (csr_data),
    .wb_valid     (wb_valid),
    .wb_pc        (wb_pc),
    .wb_gpr_wen   (wb_gpr_wen),
    .wb_rd        (wb_rd),
    .wb_gpr_wdata (wb_gpr_wdata),
    .wb_csr_op    (wb_csr_op),
    .wb_csr_addr  (wb_csr_addr),
    .wb_csr_wdata (wb_csr_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ##########################################################################
  // helpers
  // ##########################################################################

  task automatic load_golden();
    int          fd;
    int          rc;
    int          line_no;
    string       line;
    string       name;
    byte         first;
    logic        f_valid;
    logic        f_wen;
    logic [reg_addr_w-1:0] f_rd;
    logic [reg_addr_w-1:0] f_rs1;
    logic [reg_addr_w-1:0] f_rs2;
    logic [xlen-1:0]       f_gwdata;
    logic [xlen-1:0]       f_cwdata;
    logic [xlen-1:0]       f_pc;
    logic [xlen-1:0]       f_exp1;
    logic [xlen-1:0]       f_exp2;
    logic [xlen-1:0]       f_expc;
    logic [1:0]            f_op;
    logic [1:0]            f_rsel;
    logic [csr_addr_w-1:0] f_waddr;
    logic [csr_addr_w-1:0] f_raddr;
    line_no = 0;
    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", golden_path);
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc == 0) break;
      line_no++;
      first = line.getc(0);
      // comment and blank lines carry no vector
      if (first == "#" || first == "\n" || first == "\r") continue;
      rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   name, f_valid, f_wen, f_rd, f_gwdata, f_op, f_waddr, f_cwdata,
                   f_pc, f_rs1, f_rs2, f_raddr, f_rsel, f_exp1, f_exp2, f_expc);
      if (rc != 16) begin
        $display("golden file line %0d is malformed, found %0d of 16 fields", line_no, rc);
        $display("Simulation failed");
        $fatal(1);
      end
      names.push_back(name);
      vecs.push_back({f_valid, f_wen, f_rd, f_gwdata, f_op, f_waddr, f_cwdata,
                      f_pc, f_rs1, f_rs2, f_raddr, f_rsel, f_exp1, f_exp2, f_expc});
    end
    $fclose(fd);
  endtask

  task automatic drive_vector(input vec_t v);
    wb_valid     <= v.wb_valid;
    wb_gpr_wen   <= v.wb_gpr_wen;
    wb_rd        <= v.wb_rd;
    wb_gpr_wdata <= v.wb_gpr_wdata;
    wb_csr_op    <= csr_op_e'(v.wb_csr_op);
    wb_csr_addr  <= v.wb_csr_addr;
    wb_csr_wdata <= v.wb_csr_wdata;
    wb_pc        <= v.wb_pc;
    rs1          <= v.rs1;
    rs2          <= v.rs2;
    csr_addr     <= v.csr_addr;
    csr_rsel     <= csr_rsel_e'(v.csr_rsel);
  endtask

  task automatic check_value(input string test, input string port,
                             input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    assert (actual === expected) else begin
      $display("error: %s %s expected %h actual %h", test, port, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // ##########################################################################
  // main sequence
  // ##########################################################################

  initial begin
    arst_n       = 1'b0;
    rs1          = '0;
    rs2          = '0;
    csr_addr     = '0;
    csr_rsel     = csr_rsel_addr;
    wb_valid     = 1'b0;
    wb_pc        = '0;
    wb_gpr_wen   = 1'b0;
    wb_rd        = '0;
    wb_gpr_wdata = '0;
    wb_csr_op    = csr_op_none;
    wb_csr_addr  = '0;
    wb_csr_wdata = '0;

    load_golden();
    if (vecs.size() == 0) begin
      $display("the golden file holds no vectors");
      $display("Simulation failed");
      $fatal(1);
    end
    n_vec  = vecs.size();
    loaded = 1'b1;

    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;

    // reads show the state before the line's own write, which lands on the next edge
    foreach (vecs[i]) begin
      @(posedge clk);
      drive_vector(vecs[i]);
      @(negedge clk);
      #1;
      check_value(names[i], "src1", vecs[i].exp_src1, src1);
      check_value(names[i], "src2", vecs[i].exp_src2, src2);
      check_value(names[i], "csr_data", vecs[i].exp_csr, csr_data);
    end

    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    wait (loaded);
    #((n_vec + reset_cycles + margin_cycles) * clk_period);
    $display("timeout, the golden vectors did not finish in the allowed time");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule
